//--- design/axi_mon_consts.svh
`ifndef AXI_MON_CONSTS_SVH
`define AXI_MON_CONSTS_SVH

////////////////////
// Counter widths
////////////////////

// Burst counters and the read beat counter
`define AXI_MON_LGDEPTH 10

// Write beats owed, wide enough to hold a full 256 beat burst
`define AXI_MON_BEAT_W 9

// AxLEN field, burst length minus one
`define AXI_MON_LEN_W 8

////////////////////
// Stall timing
////////////////////

// Stall timers and their limits
`define AXI_MON_STALL_W 8

// Limits loaded at reset, a zero limit turns its stall class off
`define AXI_MON_REQ_LIMIT_RST 16
`define AXI_MON_RSP_LIMIT_RST 16

`endif

//--- design/axi_mon_pkg.sv
`default_nettype none

`include "axi_mon_consts.svh"

package axi_mon_pkg;

	// Widths that carry a meaning on the bus or in the counters
	typedef logic [`AXI_MON_LEN_W-1:0]   axlen_t;
	typedef logic [`AXI_MON_LGDEPTH-1:0] burst_cnt_t;
	typedef logic [`AXI_MON_BEAT_W-1:0]  beat_cnt_t;
	typedef logic [`AXI_MON_STALL_W-1:0] stall_cnt_t;
	typedef logic [1:0]                  resp_t;

	// Address request, AR uses the very same layout
	typedef struct packed {
		logic   valid;
		logic   ready;
		axlen_t len;
	} aw_chan_t;

	typedef aw_chan_t ar_chan_t;

	// Write data, only the framing bit is watched
	typedef struct packed {
		logic valid;
		logic ready;
		logic last;
	} w_chan_t;

	// Write response
	typedef struct packed {
		logic  valid;
		logic  ready;
		resp_t resp;
	} b_chan_t;

	// Read data and response
	typedef struct packed {
		logic  valid;
		logic  ready;
		logic  last;
		resp_t resp;
	} r_chan_t;

	// One flag per violation, same layout for every source
	typedef struct packed {
		logic w_no_addr;
		logic w_last;
		logic aw_overlap;
		logic b_unexp;
		logic r_unexp;
		logic r_last;
		logic aw_stall;
		logic w_stall;
		logic ar_stall;
		logic b_stall;
		logic r_stall;
		logic overflow;
	} mon_err_t;

endpackage

`default_nettype wire

//--- design/axi_mon_regs.sv
`default_nettype none

`include "axi_mon_consts.svh"

module axi_mon_regs
	import axi_mon_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_axi_reset_n,
	input  wire             i_cfg_we,
	input  wire             i_cfg_rsp,
	input  wire stall_cnt_t i_cfg_limit,
	input  wire             i_err_clr,
	input  wire mon_err_t   i_wr_viol,
	input  wire mon_err_t   i_rd_viol,
	input  wire mon_err_t   i_stall_viol,
	input  wire             i_wr_sat,
	input  wire             i_rd_sat,
	output stall_cnt_t      o_req_limit,
	output stall_cnt_t      o_rsp_limit,
	output mon_err_t        o_err
);

	stall_cnt_t req_limit;
	stall_cnt_t rsp_limit;
	mon_err_t   err;
	mon_err_t   new_viol;

	////////////////////
	// Stall limits
	////////////////////

	// Plain strobe write, i_cfg_rsp picks the response limit
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			req_limit <= stall_cnt_t'(`AXI_MON_REQ_LIMIT_RST);
			rsp_limit <= stall_cnt_t'(`AXI_MON_RSP_LIMIT_RST);
		end
		else if (i_cfg_we)
		begin
			if (i_cfg_rsp)
				rsp_limit <= i_cfg_limit;
			else
				req_limit <= i_cfg_limit;
		end
	end

	////////////////////
	// Sticky errors
	////////////////////

	// Each source only sets its own bits, so a plain OR merges them
	always_comb
	begin
		new_viol = i_wr_viol | i_rd_viol | i_stall_viol;
		// Either counter hitting its ceiling
		new_viol.overflow = new_viol.overflow | i_wr_sat | i_rd_sat;
	end

	// Clear goes first, so a violation in the clear cycle still sticks
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			err <= '0;
		else if (i_err_clr)
			err <= new_viol;
		else
			err <= err | new_viol;
	end

	assign o_req_limit = req_limit;
	assign o_rsp_limit = rsp_limit;
	assign o_err       = err;

	// Flags always start clean once reset is released
	a_err_clean_after_reset : assert property (@(posedge i_clk)
		!i_axi_reset_n |=> (o_err == '0));

endmodule

`default_nettype wire

//--- design/axi_mon_wr_track.sv
`default_nettype none

`include "axi_mon_consts.svh"

module axi_mon_wr_track
	import axi_mon_pkg::*;
(
	input  wire           i_clk,
	input  wire           i_axi_reset_n,
	input  wire aw_chan_t i_aw,
	input  wire w_chan_t  i_w,
	input  wire b_chan_t  i_b,
	output beat_cnt_t     o_wr_pending,
	output burst_cnt_t    o_awr_nbursts,
	output mon_err_t      o_viol,
	output logic          o_sat
);

	logic       aw_hs;
	logic       w_hs;
	logic       b_hs;
	logic       beat_owed;
	logic       last_owed;
	logic       burst_full;
	beat_cnt_t  wr_pending;
	burst_cnt_t awr_nbursts;

	// Handshakes, valid and ready in the same cycle
	assign aw_hs = i_aw.valid && i_aw.ready;
	assign w_hs  = i_w.valid && i_w.ready;
	assign b_hs  = i_b.valid && i_b.ready;

	assign beat_owed = (wr_pending != '0);

	// Beat landing now closes a burst, the open one or a fresh one from this AW
	assign last_owed = beat_owed ? (wr_pending == beat_cnt_t'(1)) : (i_aw.len == '0);

	////////////////////
	// Beat accounting
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			wr_pending <= '0;
		else if (aw_hs)
		begin
			// A beat with nothing owed belongs to the new burst
			if (w_hs && !beat_owed)
				wr_pending <= beat_cnt_t'(i_aw.len);
			else
				wr_pending <= beat_cnt_t'(i_aw.len) + 1'b1;
		end
		else if (w_hs && beat_owed)
			wr_pending <= wr_pending - 1'b1;
	end

	////////////////////
	// Burst accounting
	////////////////////

	assign burst_full = (awr_nbursts == '1);

	// Bursts waiting on B, AW and B together leave it unchanged
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			awr_nbursts <= '0;
		else if (aw_hs && !b_hs)
		begin
			if (!burst_full)
				awr_nbursts <= awr_nbursts + 1'b1;
		end
		else if (b_hs && !aw_hs && (awr_nbursts != '0))
			awr_nbursts <= awr_nbursts - 1'b1;
	end

	// Counter pinned at its ceiling while another AW arrives
	assign o_sat = aw_hs && !b_hs && burst_full;

	// Write side flags only, everything else stays zero
	always_comb
	begin
		o_viol = '0;
		// Data with no address ahead of it
		o_viol.w_no_addr  = w_hs && !beat_owed && !aw_hs;
		// WLAST early or missing, checked only when a beat is owed
		o_viol.w_last     = w_hs && (beat_owed || aw_hs) && (i_w.last != last_owed);
		// New address before the current burst is nearly done
		o_viol.aw_overlap = aw_hs && (wr_pending > beat_cnt_t'(1));
		o_viol.b_unexp    = i_b.valid && (awr_nbursts == '0);
	end

	assign o_wr_pending  = wr_pending;
	assign o_awr_nbursts = awr_nbursts;

	// A single burst never owes more than 256 beats
	a_pending_max : assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		wr_pending <= beat_cnt_t'(1 << `AXI_MON_LEN_W));

endmodule

`default_nettype wire

//--- design/axi_mon_rd_track.sv
`default_nettype none

`include "axi_mon_consts.svh"

module axi_mon_rd_track
	import axi_mon_pkg::*;
(
	input  wire           i_clk,
	input  wire           i_axi_reset_n,
	input  wire ar_chan_t i_ar,
	input  wire r_chan_t  i_r,
	output burst_cnt_t    o_rd_nbursts,
	output burst_cnt_t    o_rd_outstanding,
	output mon_err_t      o_viol,
	output logic          o_sat
);

	logic                      ar_hs;
	logic                      r_hs;
	logic                      out_sat;
	logic                      nb_sat;
	logic [`AXI_MON_LGDEPTH:0] out_sum;
	logic [`AXI_MON_LGDEPTH:0] nb_sum;
	burst_cnt_t                out_next;
	burst_cnt_t                nb_next;
	burst_cnt_t                rd_nbursts;
	burst_cnt_t                rd_outstanding;

	assign ar_hs = i_ar.valid && i_ar.ready;
	assign r_hs  = i_r.valid && i_r.ready;

	////////////////////
	// Next counts
	////////////////////

	// One spare bit on each sum catches the carry out
	always_comb
	begin
		out_sum = {1'b0, rd_outstanding};
		if (ar_hs)
			out_sum = out_sum + i_ar.len + 1'b1;
		if (r_hs && (out_sum != '0))
			out_sum = out_sum - 1'b1;
		out_sat  = out_sum[`AXI_MON_LGDEPTH];
		out_next = out_sat ? '1 : out_sum[`AXI_MON_LGDEPTH-1:0];

		// Bursts close on RLAST only
		nb_sum = {1'b0, rd_nbursts};
		if (ar_hs)
			nb_sum = nb_sum + 1'b1;
		if (r_hs && i_r.last && (nb_sum != '0))
			nb_sum = nb_sum - 1'b1;
		nb_sat  = nb_sum[`AXI_MON_LGDEPTH];
		nb_next = nb_sat ? '1 : nb_sum[`AXI_MON_LGDEPTH-1:0];

		// Missing RLASTs would leave bursts with no beats, resync here
		if (nb_next > out_next)
			nb_next = out_next;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			rd_outstanding <= '0;
			rd_nbursts     <= '0;
		end
		else
		begin
			rd_outstanding <= out_next;
			rd_nbursts     <= nb_next;
		end
	end

	assign o_sat = out_sat || nb_sat;

	// Read side flags only
	always_comb
	begin
		o_viol = '0;
		// Data with nothing requested
		o_viol.r_unexp = i_r.valid && (rd_outstanding == '0);
		// Final beat without RLAST, or RLAST once every burst has closed
		o_viol.r_last  = r_hs && (rd_outstanding != '0)
			&& (((rd_outstanding == burst_cnt_t'(1)) && !i_r.last)
			|| (i_r.last && (rd_nbursts == '0)));
	end

	assign o_rd_nbursts     = rd_nbursts;
	assign o_rd_outstanding = rd_outstanding;

	// Every open burst still has at least one beat to come
	a_burst_le_beat : assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		rd_nbursts <= rd_outstanding);

endmodule

`default_nettype wire

//--- design/axi_mon_stall.sv
`default_nettype none

module axi_mon_stall
	import axi_mon_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_axi_reset_n,
	input  wire aw_chan_t   i_aw,
	input  wire w_chan_t    i_w,
	input  wire b_chan_t    i_b,
	input  wire ar_chan_t   i_ar,
	input  wire r_chan_t    i_r,
	input  wire beat_cnt_t  i_wr_pending,
	input  wire burst_cnt_t i_rd_nbursts,
	input  wire stall_cnt_t i_req_limit,
	input  wire stall_cnt_t i_rsp_limit,
	output mon_err_t        o_viol
);

	// Timer slots, request channels first
	localparam int N_TMR = 5;
	localparam int T_AW  = 0;
	localparam int T_W   = 1;
	localparam int T_AR  = 2;
	localparam int T_B   = 3;
	localparam int T_R   = 4;

	logic [N_TMR-1:0] stalled;
	logic [N_TMR-1:0] hit;
	logic             b_blocked;
	stall_cnt_t       timer [N_TMR];
	stall_cnt_t       limit [N_TMR];

	// Back-pressure on B excuses the write request channels
	assign b_blocked = i_b.valid && !i_b.ready;

	////////////////////
	// Stall conditions
	////////////////////

	always_comb
	begin
		// Only counts while the slave is free to take a new address
		stalled[T_AW] = i_aw.valid && !i_aw.ready && (i_wr_pending == '0) && !b_blocked;
		stalled[T_W]  = i_w.valid && !i_w.ready && (i_wr_pending != '0) && !b_blocked;
		// Pending read data can hold off the next address
		stalled[T_AR] = i_ar.valid && !i_ar.ready && !i_r.valid && (i_rd_nbursts == '0);
		stalled[T_B]  = i_b.valid && !i_b.ready;
		stalled[T_R]  = i_r.valid && !i_r.ready;
	end

	// Stalled cycle number limit, a zero limit never fires
	always_comb
	begin
		for (int i = 0; i < N_TMR; i++)
		begin
			limit[i] = (i < T_B) ? i_req_limit : i_rsp_limit;
			hit[i]   = stalled[i] && (limit[i] != '0) && (timer[i] == limit[i] - 1'b1);
		end
	end

	////////////////////
	// Timers
	////////////////////

	// Count consecutive stalled cycles, hold at the top
	always_ff @(posedge i_clk)
	begin
		for (int i = 0; i < N_TMR; i++)
		begin
			if (!i_axi_reset_n || !stalled[i])
				timer[i] <= '0;
			else if (timer[i] != '1)
				timer[i] <= timer[i] + 1'b1;
		end
	end

	always_comb
	begin
		o_viol = '0;
		o_viol.aw_stall = hit[T_AW];
		o_viol.w_stall  = hit[T_W];
		o_viol.ar_stall = hit[T_AR];
		o_viol.b_stall  = hit[T_B];
		o_viol.r_stall  = hit[T_R];
	end

endmodule

`default_nettype wire

//--- design/axi_mon_top.sv
`default_nettype none

module axi_mon_top
	import axi_mon_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_axi_reset_n,
	input  wire aw_chan_t   i_aw,
	input  wire w_chan_t    i_w,
	input  wire b_chan_t    i_b,
	input  wire ar_chan_t   i_ar,
	input  wire r_chan_t    i_r,
	input  wire             i_cfg_we,
	input  wire             i_cfg_rsp,
	input  wire stall_cnt_t i_cfg_limit,
	input  wire             i_err_clr,
	output beat_cnt_t       o_wr_pending,
	output burst_cnt_t      o_awr_nbursts,
	output burst_cnt_t      o_rd_nbursts,
	output burst_cnt_t      o_rd_outstanding,
	output mon_err_t        o_err
);

	// Counters also feed the stall exemptions
	beat_cnt_t  wr_pending;
	burst_cnt_t rd_nbursts;
	mon_err_t   wr_viol;
	mon_err_t   rd_viol;
	mon_err_t   stall_viol;
	logic       wr_sat;
	logic       rd_sat;
	stall_cnt_t req_limit;
	stall_cnt_t rsp_limit;

	////////////////////
	// Trackers
	////////////////////

	axi_mon_wr_track u_wr_track (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_aw          (i_aw),
		.i_w           (i_w),
		.i_b           (i_b),
		.o_wr_pending  (wr_pending),
		.o_awr_nbursts (o_awr_nbursts),
		.o_viol        (wr_viol),
		.o_sat         (wr_sat)
	);

	axi_mon_rd_track u_rd_track (
		.i_clk            (i_clk),
		.i_axi_reset_n    (i_axi_reset_n),
		.i_ar             (i_ar),
		.i_r              (i_r),
		.o_rd_nbursts     (rd_nbursts),
		.o_rd_outstanding (o_rd_outstanding),
		.o_viol           (rd_viol),
		.o_sat            (rd_sat)
	);

	// Stall timers against the configured limits
	axi_mon_stall u_stall (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_aw          (i_aw),
		.i_w           (i_w),
		.i_b           (i_b),
		.i_ar          (i_ar),
		.i_r           (i_r),
		.i_wr_pending  (wr_pending),
		.i_rd_nbursts  (rd_nbursts),
		.i_req_limit   (req_limit),
		.i_rsp_limit   (rsp_limit),
		.o_viol        (stall_viol)
	);

	// Limits and the sticky flags
	axi_mon_regs u_regs (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_cfg_we      (i_cfg_we),
		.i_cfg_rsp     (i_cfg_rsp),
		.i_cfg_limit   (i_cfg_limit),
		.i_err_clr     (i_err_clr),
		.i_wr_viol     (wr_viol),
		.i_rd_viol     (rd_viol),
		.i_stall_viol  (stall_viol),
		.i_wr_sat      (wr_sat),
		.i_rd_sat      (rd_sat),
		.o_req_limit   (req_limit),
		.o_rsp_limit   (rsp_limit),
		.o_err         (o_err)
	);

	assign o_wr_pending = wr_pending;
	assign o_rd_nbursts = rd_nbursts;

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`default_nettype none

// Free running testbench clock
module tb_clk_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		o_clk = 1'b0;
		// Half period per toggle
		forever
			#(PERIOD_NS / 2.0) o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

//--- sim/axi_mon_tb.sv
`default_nettype none

`include "axi_mon_consts.svh"

module axi_mon_tb
	import axi_mon_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	// One table row with inputs held for one cycle
	typedef struct packed {
		aw_chan_t   aw;
		w_chan_t    w;
		b_chan_t    b;
		ar_chan_t   ar;
		r_chan_t    r;
		logic       cfg_we;
		logic       cfg_rsp;
		stall_cnt_t cfg_limit;
		logic       err_clr;
	} stim_t;

	// Outputs expected one cycle after the row
	typedef struct packed {
		beat_cnt_t  wr_pending;
		burst_cnt_t awr_nbursts;
		burst_cnt_t rd_nbursts;
		burst_cnt_t rd_outstanding;
		mon_err_t   err;
	} expect_t;

	logic       clk;
	logic       axi_reset_n;
	aw_chan_t   aw;
	w_chan_t    w;
	b_chan_t    b;
	ar_chan_t   ar;
	r_chan_t    r;
	logic       cfg_we;
	logic       cfg_rsp;
	stall_cnt_t cfg_limit;
	logic       err_clr;
	beat_cnt_t  wr_pending;
	burst_cnt_t awr_nbursts;
	burst_cnt_t rd_nbursts;
	burst_cnt_t rd_outstanding;
	mon_err_t   err;

	stim_t      stim_q [$];
	expect_t    exp_q [$];
	int         errors;
	int         cycles;
	int         cycle_limit;

	tb_clk_gen #(.PERIOD_NS(4.0)) u_clk_gen (.o_clk(clk));

	axi_mon_top u_axi_mon_top (
		.i_clk            (clk),
		.i_axi_reset_n    (axi_reset_n),
		.i_aw             (aw),
		.i_w              (w),
		.i_b              (b),
		.i_ar             (ar),
		.i_r              (r),
		.i_cfg_we         (cfg_we),
		.i_cfg_rsp        (cfg_rsp),
		.i_cfg_limit      (cfg_limit),
		.i_err_clr        (err_clr),
		.o_wr_pending     (wr_pending),
		.o_awr_nbursts    (awr_nbursts),
		.o_rd_nbursts     (rd_nbursts),
		.o_rd_outstanding (rd_outstanding),
		.o_err            (err)
	);

	////////////////////
	// Channel helpers
	////////////////////

	// Accepted address request for AW or AR
	function automatic aw_chan_t addr_accept(int len);
		aw_chan_t c;
		c.valid = 1'b1;
		c.ready = 1'b1;
		c.len   = axlen_t'(len);
		return c;
	endfunction

	// Address waiting on ready
	function automatic aw_chan_t addr_hold();
		aw_chan_t c;
		c = '0;
		c.valid = 1'b1;
		return c;
	endfunction

	function automatic w_chan_t wdata_accept(logic last);
		w_chan_t c;
		c.valid = 1'b1;
		c.ready = 1'b1;
		c.last  = last;
		return c;
	endfunction

	function automatic b_chan_t wresp_accept();
		b_chan_t c;
		c = '0;
		c.valid = 1'b1;
		c.ready = 1'b1;
		return c;
	endfunction

	function automatic r_chan_t rdata_accept(logic last);
		r_chan_t c;
		c = '0;
		c.valid = 1'b1;
		c.ready = 1'b1;
		c.last  = last;
		return c;
	endfunction

	function automatic r_chan_t rdata_hold();
		r_chan_t c;
		c = '0;
		c.valid = 1'b1;
		return c;
	endfunction

	////////////////////
	// Table building
	////////////////////

	task automatic add_row(aw_chan_t a, w_chan_t wd, b_chan_t br, ar_chan_t ra, r_chan_t rd);
		stim_t s;
		s = '0;
		s.aw = a;
		s.w  = wd;
		s.b  = br;
		s.ar = ra;
		s.r  = rd;
		stim_q.push_back(s);
	endtask

	task automatic add_cfg(logic rsp, int limit);
		stim_t s;
		s = '0;
		s.cfg_we    = 1'b1;
		s.cfg_rsp   = rsp;
		s.cfg_limit = stall_cnt_t'(limit);
		stim_q.push_back(s);
	endtask

	task automatic add_clear();
		stim_t s;
		s = '0;
		s.err_clr = 1'b1;
		stim_q.push_back(s);
	endtask

	task automatic add_idle(int n);
		repeat (n)
			add_row('0, '0, '0, '0, '0);
	endtask

	task automatic build_table();
		int len_a;
		int len_b;
		// Single beat write followed by its B
		add_row(addr_accept(0), '0, '0, '0, '0);
		add_row('0, wdata_accept(1'b1), '0, '0, '0);
		add_row('0, '0, wresp_accept(), '0, '0);
		// Four beats with the next AW riding on the last W
		len_a = int'($urandom_range(3, 0));
		add_row(addr_accept(3), '0, '0, '0, '0);
		repeat (3)
			add_row('0, wdata_accept(1'b0), '0, '0, '0);
		add_row(addr_accept(len_a), wdata_accept(1'b1), '0, '0, '0);
		repeat (len_a)
			add_row('0, wdata_accept(1'b0), '0, '0, '0);
		add_row('0, wdata_accept(1'b1), '0, '0, '0);
		add_row('0, '0, wresp_accept(), '0, '0);
		add_row('0, '0, wresp_accept(), '0, '0);
		// Two reads in flight and drained in order
		len_a = int'($urandom_range(3, 0));
		len_b = int'($urandom_range(3, 0));
		add_row('0, '0, '0, addr_accept(len_a), '0);
		add_row('0, '0, '0, addr_accept(len_b), '0);
		repeat (len_a)
			add_row('0, '0, '0, '0, rdata_accept(1'b0));
		add_row('0, '0, '0, '0, rdata_accept(1'b1));
		repeat (len_b)
			add_row('0, '0, '0, '0, rdata_accept(1'b0));
		add_row('0, '0, '0, '0, rdata_accept(1'b1));
		add_idle(1);
		// Early WLAST
		add_row(addr_accept(1), '0, '0, '0, '0);
		add_row('0, wdata_accept(1'b1), '0, '0, '0);
		add_row('0, wdata_accept(1'b1), '0, '0, '0);
		add_row('0, '0, wresp_accept(), '0, '0);
		add_clear();
		// W with no address
		add_row('0, wdata_accept(1'b1), '0, '0, '0);
		add_clear();
		// AW while two beats still owed
		add_row(addr_accept(2), '0, '0, '0, '0);
		add_row('0, wdata_accept(1'b0), '0, '0, '0);
		add_row(addr_accept(0), '0, '0, '0, '0);
		add_row('0, wdata_accept(1'b1), '0, '0, '0);
		add_row('0, '0, wresp_accept(), '0, '0);
		add_row('0, '0, wresp_accept(), '0, '0);
		add_clear();
		// B and R with nothing pending
		add_row('0, '0, wresp_accept(), '0, '0);
		add_clear();
		add_row('0, '0, '0, '0, rdata_accept(1'b1));
		add_clear();
		// Single beat read closed without RLAST
		add_row('0, '0, '0, addr_accept(0), '0);
		add_row('0, '0, '0, '0, rdata_accept(1'b0));
		add_clear();
		// Request stall where two cycles pass and three trip
		add_cfg(1'b0, 3);
		repeat (2)
			add_row(addr_hold(), '0, '0, '0, '0);
		add_idle(1);
		repeat (3)
			add_row(addr_hold(), '0, '0, '0, '0);
		add_idle(1);
		add_clear();
		// Response stall on R
		add_cfg(1'b1, 2);
		add_row('0, '0, '0, addr_accept(0), '0);
		repeat (2)
			add_row('0, '0, '0, '0, rdata_hold());
		add_row('0, '0, '0, '0, rdata_accept(1'b1));
		add_clear();
		// Zero limits turn stall checks off
		add_cfg(1'b0, 0);
		add_cfg(1'b1, 0);
		add_row('0, '0, '0, addr_accept(0), '0);
		// Long enough for a timer to reach its top value
		repeat ((1 << `AXI_MON_STALL_W) + 4)
			add_row(addr_hold(), '0, '0, '0, rdata_hold());
		add_row('0, '0, '0, '0, rdata_accept(1'b1));
		add_idle(2);
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Walks the table and records the outputs due after each row
	task automatic run_model();
		int       pend;
		int       wbursts;
		int       rnb;
		int       rout;
		int       req_lim;
		int       rsp_lim;
		int       lim;
		int       tmr [5];
		logic     aw_hs;
		logic     w_hs;
		logic     b_hs;
		logic     ar_hs;
		logic     r_hs;
		logic     last_beat;
		logic     b_busy;
		logic [4:0] stl;
		logic [4:0] hit;
		mon_err_t sticky;
		mon_err_t viol;
		stim_t    s;
		expect_t  e;
		pend    = 0;
		wbursts = 0;
		rnb     = 0;
		rout    = 0;
		req_lim = `AXI_MON_REQ_LIMIT_RST;
		rsp_lim = `AXI_MON_RSP_LIMIT_RST;
		sticky  = '0;
		foreach (tmr[k])
			tmr[k] = 0;
		foreach (stim_q[i])
		begin
			s     = stim_q[i];
			aw_hs = s.aw.valid && s.aw.ready;
			w_hs  = s.w.valid && s.w.ready;
			b_hs  = s.b.valid && s.b.ready;
			ar_hs = s.ar.valid && s.ar.ready;
			r_hs  = s.r.valid && s.r.ready;
			viol  = '0;
			// Write side rules
			last_beat       = (pend == 1) || ((pend == 0) && (s.aw.len == 0));
			viol.w_no_addr  = w_hs && (pend == 0) && !aw_hs;
			viol.w_last     = w_hs && ((pend != 0) || aw_hs) && (s.w.last != last_beat);
			viol.aw_overlap = aw_hs && (pend > 1);
			viol.b_unexp    = s.b.valid && (wbursts == 0);
			// Read side rules
			viol.r_unexp = s.r.valid && (rout == 0);
			viol.r_last  = r_hs && (rout != 0)
				&& (((rout == 1) && !s.r.last) || (s.r.last && (rnb == 0)));
			// Stall slots in the order aw w ar b r
			b_busy = s.b.valid && !s.b.ready;
			stl[0] = s.aw.valid && !s.aw.ready && (pend == 0) && !b_busy;
			stl[1] = s.w.valid && !s.w.ready && (pend != 0) && !b_busy;
			stl[2] = s.ar.valid && !s.ar.ready && !s.r.valid && (rnb == 0);
			stl[3] = b_busy;
			stl[4] = s.r.valid && !s.r.ready;
			for (int k = 0; k < 5; k++)
			begin
				lim    = (k < 3) ? req_lim : rsp_lim;
				hit[k] = stl[k] && (lim != 0) && (tmr[k] == lim - 1);
				tmr[k] = stl[k] ? tmr[k] + 1 : 0;
			end
			viol.aw_stall = hit[0];
			viol.w_stall  = hit[1];
			viol.ar_stall = hit[2];
			viol.b_stall  = hit[3];
			viol.r_stall  = hit[4];
			// Counter updates
			if (aw_hs)
				pend = int'(s.aw.len) + ((w_hs && (pend == 0)) ? 0 : 1);
			else if (w_hs && (pend > 0))
				pend--;
			wbursts = wbursts + int'(aw_hs) - int'(b_hs);
			if (wbursts < 0)
				wbursts = 0;
			if (ar_hs)
			begin
				rout = rout + int'(s.ar.len) + 1;
				rnb++;
			end
			if (r_hs && (rout > 0))
				rout--;
			if (r_hs && s.r.last && (rnb > 0))
				rnb--;
			if (rnb > rout)
				rnb = rout;
			if (s.cfg_we && s.cfg_rsp)
				rsp_lim = int'(s.cfg_limit);
			else if (s.cfg_we)
				req_lim = int'(s.cfg_limit);
			sticky = s.err_clr ? viol : (sticky | viol);
			e.wr_pending     = beat_cnt_t'(pend);
			e.awr_nbursts    = burst_cnt_t'(wbursts);
			e.rd_nbursts     = burst_cnt_t'(rnb);
			e.rd_outstanding = burst_cnt_t'(rout);
			e.err            = sticky;
			exp_q.push_back(e);
		end
	endtask

	////////////////////
	// Drive and check
	////////////////////

	task automatic drive_row(stim_t s);
		aw        <= s.aw;
		w         <= s.w;
		b         <= s.b;
		ar        <= s.ar;
		r         <= s.r;
		cfg_we    <= s.cfg_we;
		cfg_rsp   <= s.cfg_rsp;
		cfg_limit <= s.cfg_limit;
		err_clr   <= s.err_clr;
	endtask

	task automatic check_value(string name, logic [31:0] exp_v, logic [31:0] got_v);
		if (exp_v !== got_v)
		begin
			errors++;
			$display("Mismatch %s exp 0x%0h got 0x%0h", name, exp_v, got_v);
		end
	endtask

	task automatic check_outputs(expect_t e, int row);
		check_value($sformatf("o_wr_pending row %0d", row), 32'(e.wr_pending), 32'(wr_pending));
		check_value($sformatf("o_awr_nbursts row %0d", row), 32'(e.awr_nbursts),
			32'(awr_nbursts));
		check_value($sformatf("o_rd_nbursts row %0d", row), 32'(e.rd_nbursts), 32'(rd_nbursts));
		check_value($sformatf("o_rd_outstanding row %0d", row), 32'(e.rd_outstanding),
			32'(rd_outstanding));
		check_value($sformatf("o_err row %0d", row), 32'(e.err), 32'(err));
	endtask

	// Watchdog on the whole run
	initial
	begin
		cycles = 0;
		wait (cycle_limit != 0);
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run did not finish within %0d cycles", cycle_limit);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		errors      = 0;
		cycle_limit = 0;
		axi_reset_n <= 1'b0;
		drive_row('0);
		void'($urandom(74));
		build_table();
		run_model();
		cycle_limit = stim_q.size() + 20;
		repeat (5)
			@(posedge clk);
		axi_reset_n <= 1'b1;
		// Everything starts at zero
		@(negedge clk);
		check_value("o_wr_pending", 32'h0, 32'(wr_pending));
		check_value("o_awr_nbursts", 32'h0, 32'(awr_nbursts));
		check_value("o_rd_nbursts", 32'h0, 32'(rd_nbursts));
		check_value("o_rd_outstanding", 32'h0, 32'(rd_outstanding));
		check_value("o_err", 32'h0, 32'(err));
		// Row i goes out while the result of row i-1 is read back
		for (int i = 0; i <= stim_q.size(); i++)
		begin
			@(posedge clk);
			if (i < stim_q.size())
				drive_row(stim_q[i]);
			else
				drive_row('0);
			@(negedge clk);
			if (i > 0)
				check_outputs(exp_q[i-1], i - 1);
		end
		$display("Ran %0d rows, %0d errors", stim_q.size(), errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- axi_mon.f
+incdir+design
design/axi_mon_pkg.sv
design/axi_mon_regs.sv
design/axi_mon_wr_track.sv
design/axi_mon_rd_track.sv
design/axi_mon_stall.sv
design/axi_mon_top.sv
sim/tb_clk_gen.sv
sim/axi_mon_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the AXI monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f axi_mon.f --top-module axi_mon_tb \
	-Mdir "$BUILD_DIR" -o axi_mon_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/axi_mon_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG_FILE"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG_FILE"
exit 1
